//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    // Major opcodes, instruction[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } rv_opcode_e;

    localparam logic [6:0] funct7_base = 7'b0000000;
    // SUB, SRA and SRAI
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Load widths, the unsigned ones have bit 2 set
    localparam logic [2:0] f3_lb   = 3'b000;
    localparam logic [2:0] f3_lh   = 3'b001;
    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_lbu  = 3'b100;
    localparam logic [2:0] f3_lhu  = 3'b101;
    localparam logic [2:0] f3_sw   = 3'b010;
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [11:0] f12_ecall  = 12'h000;
    localparam logic [11:0] f12_ebreak = 12'h001;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h00000013;

endpackage

//--- source/exe_ctl_pkg.sv
package exe_ctl_pkg;

    // Encodings kept from the earlier execute stage
    typedef enum logic [3:0] {
        alu_and    = 4'b0000,
        alu_or     = 4'b0001,
        alu_xor    = 4'b0010,
        alu_add    = 4'b0011,
        alu_sub    = 4'b0100,
        alu_pass_b = 4'b0110,
        alu_sll    = 4'b0111,
        alu_srl    = 4'b1000,
        alu_sra    = 4'b1010,
        alu_sltu   = 4'b1011,
        alu_slt    = 4'b1100,
        // FENCE, ECALL, EBREAK and anything illegal
        alu_zero   = 4'b1111
    } alu_op_e;

    // Immediate formats
    typedef enum logic [2:0] {
        imm_none = 3'd0,
        imm_i    = 3'd1,
        imm_s    = 3'd2,
        imm_b    = 3'd3,
        imm_u    = 3'd4,
        imm_j    = 3'd5
    } imm_sel_e;

endpackage

//--- source/execute_ctl.sv
`timescale 1ns/1ps

module execute_ctl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic [rv_isa_pkg::xlen-1:0] data_a,
    input  logic [rv_isa_pkg::xlen-1:0] data_b,
    input  logic [rv_isa_pkg::xlen-1:0] pc_de,
    input  logic [rv_isa_pkg::xlen-1:0] instruction,
    output logic                        a_sel,
    output logic                        b_sel,
    output exe_ctl_pkg::imm_sel_e       imm_sel,
    output exe_ctl_pkg::alu_op_e        alu_op,
    output logic                        sign,
    output logic                        illegal,
    output logic [rv_isa_pkg::xlen-1:0] data_a_exe,
    output logic [rv_isa_pkg::xlen-1:0] data_b_exe,
    output logic [rv_isa_pkg::xlen-1:0] pc_exe,
    output logic [rv_isa_pkg::xlen-1:0] instr_exe
);
    import rv_isa_pkg::*;
    import exe_ctl_pkg::*;

    rv_opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_reg;
    logic       f7_alt;
    logic       f7_ok;

    logic       nxt_a_sel;
    logic       nxt_b_sel;
    imm_sel_e   nxt_imm_sel;
    alu_op_e    nxt_alu_op;
    logic       nxt_sign;
    logic       nxt_illegal;

    assign opcode = rv_opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign is_reg = (opcode == op_reg);
    assign f7_alt = (funct7 == funct7_alt);
    // Alternate funct7 is only defined for add/sub and the right shifts
    assign f7_ok  = (funct7 == funct7_base) || (f7_alt && (funct3 == f3_add || funct3 == f3_srl));

    always_comb begin
        nxt_a_sel   = 1'b0;
        nxt_b_sel   = 1'b1;
        nxt_imm_sel = imm_none;
        nxt_alu_op  = alu_add;
        nxt_sign    = 1'b0;
        nxt_illegal = 1'b0;
        case (opcode)
            op_lui: begin
                nxt_imm_sel = imm_u;
                nxt_alu_op  = alu_pass_b;
            end
            op_auipc: begin
                nxt_a_sel   = 1'b1;
                nxt_imm_sel = imm_u;
            end
            op_jal: begin
                nxt_a_sel   = 1'b1;
                nxt_imm_sel = imm_j;
            end
            op_jalr: begin
                nxt_imm_sel = imm_i;
                nxt_illegal = (funct3 != f3_jalr);
            end
            // Target address here, the condition is evaluated in the ALU stage
            op_branch: begin
                nxt_a_sel   = 1'b1;
                nxt_imm_sel = imm_b;
                nxt_illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            op_load: begin
                nxt_imm_sel = imm_i;
                case (funct3)
                    f3_lb, f3_lh, f3_lw: nxt_sign = 1'b1;
                    f3_lbu, f3_lhu:      nxt_sign = 1'b0;
                    default:             nxt_illegal = 1'b1;
                endcase
            end
            op_store: begin
                nxt_imm_sel = imm_s;
                nxt_illegal = (funct3 > f3_sw);
            end
            op_imm, op_reg: begin
                nxt_b_sel   = !is_reg;
                nxt_imm_sel = is_reg ? imm_none : imm_i;
                // For OP-IMM only the shifts carry a funct7
                if ((is_reg || funct3 == f3_sll || funct3 == f3_srl) && !f7_ok) begin
                    nxt_illegal = 1'b1;
                end
                case (funct3)
                    f3_add:  nxt_alu_op = (is_reg && f7_alt) ? alu_sub : alu_add;
                    f3_sll:  nxt_alu_op = alu_sll;
                    f3_slt:  nxt_alu_op = alu_slt;
                    f3_sltu: nxt_alu_op = alu_sltu;
                    f3_xor:  nxt_alu_op = alu_xor;
                    f3_srl:  nxt_alu_op = f7_alt ? alu_sra : alu_srl;
                    f3_or:   nxt_alu_op = alu_or;
                    default: nxt_alu_op = alu_and;
                endcase
            end
            op_fence: begin
                nxt_b_sel  = 1'b0;
                nxt_alu_op = alu_zero;
            end
            op_system: begin
                nxt_b_sel   = 1'b0;
                nxt_alu_op  = alu_zero;
                nxt_illegal = (instruction[31:20] != f12_ecall) &&
                              (instruction[31:20] != f12_ebreak);
            end
            default: nxt_illegal = 1'b1;
        endcase
        if (nxt_illegal) begin
            nxt_a_sel   = 1'b0;
            nxt_b_sel   = 1'b0;
            nxt_imm_sel = imm_none;
            nxt_alu_op  = alu_zero;
            nxt_sign    = 1'b0;
        end
    end

    // Pipeline register between decode and ALU, reset decodes as a NOP
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_sel      <= 1'b0;
            b_sel      <= 1'b1;
            imm_sel    <= imm_i;
            alu_op     <= alu_add;
            sign       <= 1'b0;
            illegal    <= 1'b0;
            data_a_exe <= '0;
            data_b_exe <= '0;
            pc_exe     <= '0;
            instr_exe  <= nop_instr;
        end else if (!stall) begin
            a_sel      <= nxt_a_sel;
            b_sel      <= nxt_b_sel;
            imm_sel    <= nxt_imm_sel;
            alu_op     <= nxt_alu_op;
            sign       <= nxt_sign;
            illegal    <= nxt_illegal;
            data_a_exe <= data_a;
            data_b_exe <= data_b;
            pc_exe     <= pc_de;
            instr_exe  <= instruction;
        end
    end

    illegal_forces_zero: assert property (
        @(posedge clk) disable iff (rst) !(illegal && alu_op != alu_zero)
    ) else $error("illegal instruction handed to the ALU with a live operation");

endmodule

//--- source/execute_alu.sv
`timescale 1ns/1ps

module execute_alu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        a_sel,
    input  logic                        b_sel,
    input  exe_ctl_pkg::imm_sel_e       imm_sel,
    input  exe_ctl_pkg::alu_op_e        alu_op,
    input  logic                        sign,
    input  logic                        illegal,
    input  logic [rv_isa_pkg::xlen-1:0] data_a_exe,
    input  logic [rv_isa_pkg::xlen-1:0] data_b_exe,
    input  logic [rv_isa_pkg::xlen-1:0] pc_exe,
    input  logic [rv_isa_pkg::xlen-1:0] instr_exe,
    output logic [rv_isa_pkg::xlen-1:0] result,
    output logic                        branch_taken,
    output logic                        load_signed,
    output logic                        illegal_out,
    output logic [rv_isa_pkg::xlen-1:0] instr_out
);
    import rv_isa_pkg::*;
    import exe_ctl_pkg::*;

    logic [xlen-1:0] imm;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_out;
    logic            take;

    always_comb begin
        case (imm_sel)
            imm_i:   imm = {{20{instr_exe[31]}}, instr_exe[31:20]};
            imm_s:   imm = {{20{instr_exe[31]}}, instr_exe[31:25], instr_exe[11:7]};
            imm_b:   imm = {{19{instr_exe[31]}}, instr_exe[31], instr_exe[7],
                            instr_exe[30:25], instr_exe[11:8], 1'b0};
            imm_u:   imm = {instr_exe[31:12], 12'b0};
            imm_j:   imm = {{11{instr_exe[31]}}, instr_exe[31], instr_exe[19:12],
                            instr_exe[20], instr_exe[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign op_a  = a_sel ? pc_exe : data_a_exe;
    assign op_b  = b_sel ? imm : data_b_exe;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_pass_b: alu_out = op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $signed(op_a) >>> shamt;
            alu_sltu:   alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:    alu_out = '0;
        endcase
    end

    // Branch condition always compares the register operands, not op_a/op_b
    always_comb begin
        take = 1'b0;
        if (instr_exe[6:0] == op_branch) begin
            case (instr_exe[14:12])
                f3_beq:  take = (data_a_exe == data_b_exe);
                f3_bne:  take = (data_a_exe != data_b_exe);
                f3_blt:  take = $signed(data_a_exe) < $signed(data_b_exe);
                f3_bge:  take = $signed(data_a_exe) >= $signed(data_b_exe);
                f3_bltu: take = data_a_exe < data_b_exe;
                f3_bgeu: take = data_a_exe >= data_b_exe;
                default: take = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result       <= '0;
            branch_taken <= 1'b0;
            load_signed  <= 1'b0;
            illegal_out  <= 1'b0;
            instr_out    <= nop_instr;
        end else if (!stall) begin
            result       <= alu_out;
            branch_taken <= take;
            load_signed  <= sign;
            illegal_out  <= illegal;
            instr_out    <= instr_exe;
        end
    end

    taken_only_on_branch: assert property (
        @(posedge clk) disable iff (rst) branch_taken |-> instr_out[6:0] == op_branch
    ) else $error("branch_taken raised for a non-branch instruction");

    // A stalled edge must leave every output where it was
    hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> $stable({result, branch_taken, load_signed, illegal_out, instr_out})
    ) else $error("execute outputs moved during a stall");

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic [rv_isa_pkg::xlen-1:0] data_a,
    input  logic [rv_isa_pkg::xlen-1:0] data_b,
    input  logic [rv_isa_pkg::xlen-1:0] pc_de,
    input  logic [rv_isa_pkg::xlen-1:0] instruction,
    output logic [rv_isa_pkg::xlen-1:0] result,
    output logic                        branch_taken,
    output logic                        load_signed,
    output logic                        illegal_out,
    output logic [rv_isa_pkg::xlen-1:0] instr_out
);
    import rv_isa_pkg::*;
    import exe_ctl_pkg::*;

    logic            a_sel;
    logic            b_sel;
    imm_sel_e        imm_sel;
    alu_op_e         alu_op;
    logic            sign;
    logic            illegal;
    logic [xlen-1:0] data_a_exe;
    logic [xlen-1:0] data_b_exe;
    logic [xlen-1:0] pc_exe;
    logic [xlen-1:0] instr_exe;

    // Decode and operand capture
    execute_ctl u_ctl (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .data_a      (data_a),
        .data_b      (data_b),
        .pc_de       (pc_de),
        .instruction (instruction),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .imm_sel     (imm_sel),
        .alu_op      (alu_op),
        .sign        (sign),
        .illegal     (illegal),
        .data_a_exe  (data_a_exe),
        .data_b_exe  (data_b_exe),
        .pc_exe      (pc_exe),
        .instr_exe   (instr_exe)
    );

    execute_alu u_alu (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .a_sel        (a_sel),
        .b_sel        (b_sel),
        .imm_sel      (imm_sel),
        .alu_op       (alu_op),
        .sign         (sign),
        .illegal      (illegal),
        .data_a_exe   (data_a_exe),
        .data_b_exe   (data_b_exe),
        .pc_exe       (pc_exe),
        .instr_exe    (instr_exe),
        .result       (result),
        .branch_taken (branch_taken),
        .load_signed  (load_signed),
        .illegal_out  (illegal_out),
        .instr_out    (instr_out)
    );

endmodule

//--- sim/execute_model.svh
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// Packed as {result, branch_taken, load_signed, illegal}
function automatic logic [xlen+2:0] execute_ref(input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b,
                                                input logic [xlen-1:0] pc,
                                                input logic [xlen-1:0] ins);
    logic [2:0]      f3;
    logic            alt;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] rhs;
    logic [xlen-1:0] res;
    logic            take;
    logic            sgn;
    logic            bad;
    f3    = ins[14:12];
    alt   = (ins[31:25] == funct7_alt);
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    res   = '0;
    take  = 1'b0;
    sgn   = 1'b0;
    bad   = 1'b0;
    case (ins[6:0])
        op_lui:   res = imm_u;
        op_auipc: res = pc + imm_u;
        op_jal:   res = pc + imm_j;
        op_jalr: begin
            res = a + imm_i;
            bad = (f3 != 3'd0);
        end
        op_branch: begin
            res = pc + imm_b;
            case (f3)
                3'd0:    take = (a == b);
                3'd1:    take = (a != b);
                3'd4:    take = ($signed(a) < $signed(b));
                3'd5:    take = ($signed(a) >= $signed(b));
                3'd6:    take = (a < b);
                3'd7:    take = (a >= b);
                default: bad = 1'b1;
            endcase
        end
        op_load: begin
            res = a + imm_i;
            sgn = (f3 < 3'd3);
            bad = (f3 == 3'd3) || (f3 > 3'd5);
        end
        op_store: begin
            res = a + imm_s;
            bad = (f3 > 3'd2);
        end
        op_imm, op_reg: begin
            rhs = (ins[6:0] == op_reg) ? b : imm_i;
            // funct7 matters for OP and for the immediate shifts
            if (ins[6:0] == op_reg || f3 == 3'd1 || f3 == 3'd5) begin
                bad = (ins[31:25] != 7'd0) && !(alt && (f3 == 3'd0 || f3 == 3'd5));
            end
            case (f3)
                3'd0: res = (ins[6:0] == op_reg && alt) ? a - rhs : a + rhs;
                3'd1: res = a << rhs[4:0];
                3'd2: res = {31'd0, $signed(a) < $signed(rhs)};
                3'd3: res = {31'd0, a < rhs};
                3'd4: res = a ^ rhs;
                3'd5: begin
                    if (alt) begin
                        res = $signed(a) >>> rhs[4:0];
                    end else begin
                        res = a >> rhs[4:0];
                    end
                end
                3'd6: res = a | rhs;
                default: res = a & rhs;
            endcase
        end
        op_fence:  res = '0;
        op_system: bad = (ins[31:20] > 12'h001);
        default:   bad = 1'b1;
    endcase
    if (bad) begin
        res = '0;
        sgn = 1'b0;
    end
    return {res, take, sgn, bad};
endfunction

`endif

//--- sim/execute_stage_tb.sv
`timescale 1ns/1ps

module execute_stage_tb;
    import rv_isa_pkg::*;

    `include "execute_model.svh"

    localparam int rec_w = 2 * xlen + 3;
    localparam int n_arith = 200;
    localparam int n_mem = 48;
    localparam int n_branch = 18;
    localparam int n_odd = 11;
    localparam int n_stream = 100;
    localparam int timeout_cycles = 4 * (n_arith + n_mem + n_branch + n_odd + n_stream) + 100;

    logic            clk = 1'b0;
    logic            rst;
    logic            stall;
    logic [xlen-1:0] data_a;
    logic [xlen-1:0] data_b;
    logic [xlen-1:0] pc_de;
    logic [xlen-1:0] instruction;
    logic [xlen-1:0] result;
    logic            branch_taken;
    logic            load_signed;
    logic            illegal_out;
    logic [xlen-1:0] instr_out;

    integer           seed;
    int               checks = 0;
    int               errors = 0;
    int               test_checks;
    int               test_errors;
    int               cycles = 0;
    int               i;
    string            test_name;
    logic             stall_on;
    logic             sending;
    logic             in_flight;
    logic             out_new;
    logic             held;
    logic [rec_w-1:0] snapshot;
    logic [rec_w-1:0] exp_e;
    logic [xlen-1:0]  bits;
    logic [xlen-1:0]  a;
    logic [xlen-1:0]  b;
    logic [rec_w-1:0] expect_q[$];

    execute_stage UUT (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .data_a       (data_a),
        .data_b       (data_b),
        .pc_de        (pc_de),
        .instruction  (instruction),
        .result       (result),
        .branch_taken (branch_taken),
        .load_signed  (load_signed),
        .illegal_out  (illegal_out),
        .instr_out    (instr_out)
    );

    always #2 clk = ~clk;

    task automatic check(input string what, input logic [rec_w-1:0] expected,
                         input logic [rec_w-1:0] actual);
        checks++;
        test_checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    // Encoding of one instruction class with the remaining fields taken from bits
    function automatic logic [xlen-1:0] shape_instr(input int kind, input logic [xlen-1:0] bits);
        logic [xlen-1:0] ins;
        logic [2:0]      f3;
        ins = bits;
        f3  = bits[14:12];
        case (kind)
            0, 1: begin
                ins[6:0] = (kind == 0) ? op_reg : op_imm;
                if (kind == 0 || f3 == f3_sll || f3 == f3_srl)
                    ins[31:25] = (bits[30] && (f3 == f3_srl || (kind == 0 && f3 == f3_add))) ?
                                 funct7_alt : 7'd0;
            end
            2: ins[6:0] = op_lui;
            3: ins[6:0] = op_auipc;
            4: ins[6:0] = op_jal;
            5: begin
                ins[6:0] = op_jalr;
                f3 = 3'd0;
            end
            6: begin
                ins[6:0] = op_load;
                if (f3 == 3'd3 || f3 >= 3'd6) f3 = f3 & 3'b001;
            end
            7: begin
                ins[6:0] = op_store;
                f3 = f3 % 3'd3;
            end
            default: begin
                ins[6:0] = op_branch;
                if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
            end
        endcase
        ins[14:12] = f3;
        return ins;
    endfunction

    // Holds the instruction on the inputs until an unstalled edge takes it
    task automatic send(input logic [xlen-1:0] ins, input logic [xlen-1:0] op_a,
                        input logic [xlen-1:0] op_b, input logic [xlen-1:0] pc);
        logic hold;
        do begin
            hold = stall_on && (($random(seed) & 3) == 0);
            @(posedge clk);
            instruction <= ins;
            data_a      <= op_a;
            data_b      <= op_b;
            pc_de       <= pc;
            stall       <= hold;
            sending     <= !hold;
        end while (hold);
        expect_q.push_back({execute_ref(op_a, op_b, pc, ins), ins});
    endtask

    task automatic send_random(input logic [xlen-1:0] ins);
        send(ins, $random(seed), $random(seed), $random(seed) & 32'hffff_fffc);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        @(posedge clk);
        sending <= 1'b0;
        stall   <= 1'b0;
        while (expect_q.size() != 0) @(negedge clk);
        $display("%-14s %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    // Shadow of the two pipeline slots
    always @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
            out_new   <= 1'b0;
            held      <= 1'b0;
        end else begin
            held    <= stall;
            out_new <= !stall && in_flight;
            if (!stall) in_flight <= sending;
        end
    end

    always @(negedge clk) begin
        if (out_new) begin
            if (expect_q.size() == 0) begin
                errors++;
                test_errors++;
                $display("An output appeared with no instruction waiting for it in %s", test_name);
            end else begin
                exp_e = expect_q.pop_front();
                check("result", exp_e[rec_w-1:xlen+3], result);
                check("branch_taken", exp_e[xlen+2], branch_taken);
                check("load_signed", exp_e[xlen+1], load_signed);
                check("illegal_out", exp_e[xlen], illegal_out);
                check("instr_out", exp_e[xlen-1:0], instr_out);
            end
        end
        if (held) check("stalled outputs", snapshot,
                        {result, branch_taken, load_signed, illegal_out, instr_out});
        snapshot = {result, branch_taken, load_signed, illegal_out, instr_out};
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            errors++;
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Checks passed: %0d, failed: %0d", checks - errors + 1, errors);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        seed        = 32'hf339;
        rst         = 1'b1;
        stall       = 1'b0;
        stall_on    = 1'b0;
        sending     = 1'b0;
        data_a      = '0;
        data_b      = '0;
        pc_de       = '0;
        instruction = nop_instr;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_state");
        @(negedge clk);
        check("result", 0, result);
        check("branch_taken", 0, branch_taken);
        check("load_signed", 0, load_signed);
        check("illegal_out", 0, illegal_out);
        check("instr_out", nop_instr, instr_out);
        end_test();

        start_test("arithmetic");
        for (i = 0; i < n_arith; i++) begin
            bits = $random(seed);
            bits[14:12] = 3'(i % 8);
            send_random(shape_instr((i / 8) % 2, bits));
        end
        end_test();

        start_test("upper_jump_mem");
        for (i = 0; i < n_mem; i++) begin
            bits = $random(seed);
            bits[14:12] = 3'(i / 6);
            send_random(shape_instr(2 + i % 6, bits));
        end
        end_test();

        // Equal, less signed only, less unsigned only
        start_test("branches");
        for (i = 0; i < n_branch; i++) begin
            bits = $random(seed);
            bits[14:12] = (i / 3 < 2) ? 3'(i / 3) : 3'(i / 3 + 2);
            a = $random(seed);
            b = $random(seed);
            case (i % 3)
                0: b = a;
                1: begin
                    a[31] = 1'b1;
                    b[31] = 1'b0;
                end
                default: begin
                    a[31] = 1'b0;
                    b[31] = 1'b1;
                end
            endcase
            send(shape_instr(8, bits), a, b, $random(seed) & 32'hffff_fffc);
        end
        end_test();

        start_test("illegal_system");
        send_random(32'hffffffff);
        send_random(32'h00000000);
        send_random(32'h0000005b);
        send_random(32'h02b50533);
        send_random({funct7_alt, 5'd2, 5'd1, f3_xor, 5'd3, op_reg});
        send_random({funct7_alt, 5'd4, 5'd1, f3_sll, 5'd2, op_imm});
        send_random(32'h0000b003);
        send_random(32'h0ff0000f);
        send_random(32'h00000073);
        send_random(32'h00100073);
        send_random(32'h30200073);
        end_test();

        start_test("stall_stream");
        stall_on = 1'b1;
        for (i = 0; i < n_stream; i++) begin
            send_random(shape_instr($unsigned($random(seed)) % 9, $random(seed)));
        end
        stall_on = 1'b0;
        end_test();

        $display("Checks passed: %0d, failed: %0d", checks - errors, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- execute_stage.f
+incdir+sim
source/rv_isa_pkg.sv
source/exe_ctl_pkg.sv
source/execute_ctl.sv
source/execute_alu.sv
source/execute_stage.sv
sim/execute_stage_tb.sv
